// File: include/aud_macros.svh
`ifndef AUD_MACROS_SVH
`define AUD_MACROS_SVH

// bits per audio sample
`define AUD_SAMPLE_W 16

// sample memory addressing
`define AUD_ADDR_W 6

// words in the sample memory
// always a full power of two of the address width
`define AUD_MEM_DEPTH (1 << `AUD_ADDR_W)

// speed exponent width
// covers speeds 1, 2, 4 and 8
`define AUD_SHIFT_W 2

`endif

// File: logic/aud_pkg.sv
`default_nettype none

`include "aud_macros.svh"

package aud_pkg;

	// recorder states, i2c init state not present
	typedef enum logic [2:0] {
		st_idle,
		st_rec,
		st_rec_pause,
		st_play,
		st_play_pause
	} aud_state_e;

	// signed pcm word
	typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

	// memory address
	typedef logic [`AUD_ADDR_W-1:0] addr_t;

	// one extra bit so a full memory fits
	typedef logic [`AUD_ADDR_W:0] len_t;

	// speed exponent
	typedef logic [`AUD_SHIFT_W-1:0] shift_t;

	// slow play fraction, up to 2^max_shift - 1
	typedef logic [(1 << `AUD_SHIFT_W) - 2:0] wgt_t;

endpackage

`default_nettype wire

// File: logic/aud_ctrl.sv
`default_nettype none

module aud_ctrl (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_start,
	input  logic                i_pause,
	input  logic                i_stop,
	input  logic                i_play_mode,
	input  logic                i_full,
	input  logic                i_end,
	output aud_pkg::aud_state_e o_state
);

	import aud_pkg::*;

	aud_state_e state_r, state_w;

	assign o_state = state_r;

	// transition table
	always_comb begin
		state_w = state_r;
		case (state_r)
			st_idle: begin
				// play mode level picks the direction
				if (i_start) begin
					state_w = i_play_mode ? st_play : st_rec;
				end
			end
			st_rec: begin
				// pause wins over stop
				if (i_pause) begin
					state_w = st_rec_pause;
				end else if (i_stop) begin
					state_w = st_idle;
				end
				// memory filled, auto stop
				if (i_full) begin
					state_w = st_idle;
				end
			end
			st_rec_pause: begin
				if (i_start) begin
					state_w = st_rec;
				end else if (i_stop) begin
					state_w = st_idle;
				end
			end
			st_play: begin
				if (i_pause) begin
					state_w = st_play_pause;
				end else if (i_stop) begin
					state_w = st_idle;
				end
				// last position reached
				if (i_end) begin
					state_w = st_idle;
				end
			end
			st_play_pause: begin
				if (i_start) begin
					state_w = st_play;
				end else if (i_stop) begin
					state_w = st_idle;
				end
			end
			default: begin
				state_w = st_idle;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= st_idle;
		end else begin
			state_r <= state_w;
		end
	end

endmodule

`default_nettype wire

// File: logic/aud_capture.sv
`default_nettype none

`include "aud_macros.svh"

module aud_capture (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  aud_pkg::aud_state_e i_state,
	input  logic                i_adc_valid,
	input  aud_pkg::sample_t    i_adc_data,
	output logic                o_wr_en,
	output aud_pkg::addr_t      o_wr_addr,
	output aud_pkg::sample_t    o_wr_data,
	output aud_pkg::len_t       o_len,
	output logic                o_full
);

	import aud_pkg::*;

	aud_state_e state_q;
	len_t       len_r;
	len_t       cur_len;
	logic       fresh;
	logic       accept;

	// first record cycle after idle starts over at address 0
	assign fresh   = (i_state == st_rec) && (state_q == st_idle);
	assign cur_len = fresh ? '0 : len_r;

	// length doubles as next write address
	assign o_full = (cur_len == len_t'(`AUD_MEM_DEPTH));
	assign accept = i_adc_valid && (i_state == st_rec) && !o_full;
	assign o_len  = len_r;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= st_idle;
			len_r   <= '0;
			o_wr_en <= 1'b0;
		end else begin
			state_q <= i_state;
			o_wr_en <= accept;
			// length moves with the write strobe
			len_r   <= accept ? cur_len + len_t'(1) : cur_len;
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_wr_addr <= addr_t'(cur_len);
			o_wr_data <= i_adc_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/aud_sample_ram.sv
`default_nettype none

module aud_sample_ram (
	input  logic             i_clk,
	input  logic             i_wr_en,
	input  aud_pkg::addr_t   i_wr_addr,
	input  aud_pkg::sample_t i_wr_data,
	input  logic             i_rd_en,
	input  aud_pkg::addr_t   i_rd_addr0,
	input  aud_pkg::addr_t   i_rd_addr1,
	input  aud_pkg::wgt_t    i_weight,
	input  aud_pkg::shift_t  i_shift,
	output logic             o_rd_valid,
	output aud_pkg::sample_t o_rd_data0,
	output aud_pkg::sample_t o_rd_data1,
	output aud_pkg::wgt_t    o_weight,
	output aud_pkg::shift_t  o_shift
);

	import aud_pkg::*;

	localparam int DEPTH = 2 ** $bits(addr_t);

	sample_t mem [DEPTH];

	// one write port, two registered read ports
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
		o_rd_valid <= i_rd_en;
		if (i_rd_en) begin
			o_rd_data0 <= mem[i_rd_addr0];
			o_rd_data1 <= mem[i_rd_addr1];
			// weight and shift ride along with the words
			o_weight   <= i_weight;
			o_shift    <= i_shift;
		end
	end

endmodule

`default_nettype wire

// File: logic/aud_rate_gen.sv
`default_nettype none

module aud_rate_gen (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  aud_pkg::aud_state_e i_state,
	input  logic                i_dac_req,
	input  logic                i_fast,
	input  aud_pkg::shift_t     i_speed,
	input  aud_pkg::len_t       i_len,
	output logic                o_rd_en,
	output aud_pkg::addr_t      o_rd_addr0,
	output aud_pkg::addr_t      o_rd_addr1,
	output aud_pkg::wgt_t       o_weight,
	output aud_pkg::shift_t     o_shift,
	output logic                o_end
);

	import aud_pkg::*;

	localparam int WW = $bits(wgt_t);

	len_t        p_r;
	wgt_t        k_r;
	len_t        p_next;
	wgt_t        k_next;
	len_t        p_plus1;
	len_t        last_addr;
	len_t        rd1;
	logic [WW:0] k_span;
	logic        accept;

	// requests outside play are dropped
	assign accept = i_dac_req && (i_state == st_play);

	// 2^s requests per sample in slow play
	assign k_span    = {{WW{1'b0}}, 1'b1} << i_speed;
	assign p_plus1   = p_r + len_t'(1);
	assign last_addr = i_len - len_t'(1);

	always_comb begin
		if (i_fast) begin
			// skip ahead by 2^s, no fraction
			p_next = p_r + (len_t'(1) << i_speed);
			k_next = '0;
			rd1    = p_r;
		end else begin
			// clamp neighbour to the last recorded word
			rd1 = (p_plus1 >= i_len) ? last_addr : p_plus1;
			if (k_r == wgt_t'(k_span - 1'b1)) begin
				p_next = p_plus1;
				k_next = '0;
			end else begin
				p_next = p_r;
				k_next = k_r + wgt_t'(1);
			end
		end
	end

	// combinational so ctrl leaves play right after the last read
	assign o_end = accept && (p_next >= i_len);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			p_r     <= '0;
			k_r     <= '0;
			o_rd_en <= 1'b0;
		end else begin
			o_rd_en <= accept;
			// idle rewinds, pauses keep position
			if (i_state == st_idle) begin
				p_r <= '0;
				k_r <= '0;
			end else if (accept) begin
				p_r <= p_next;
				k_r <= k_next;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_rd_addr0 <= addr_t'(p_r);
			o_rd_addr1 <= addr_t'(rd1);
			// fast play never interpolates
			o_weight   <= i_fast ? '0 : k_r;
			o_shift    <= i_fast ? '0 : i_speed;
		end
	end

endmodule

`default_nettype wire

// File: logic/aud_interp.sv
`default_nettype none

module aud_interp (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_interp,
	input  logic             i_valid,
	input  aud_pkg::sample_t i_data0,
	input  aud_pkg::sample_t i_data1,
	input  aud_pkg::wgt_t    i_weight,
	input  aud_pkg::shift_t  i_shift,
	output logic             o_dac_valid,
	output aud_pkg::sample_t o_dac_data
);

	import aud_pkg::*;

	localparam int SW = $bits(sample_t);
	localparam int WW = $bits(wgt_t);
	// room for diff times weight plus sign
	localparam int PW = SW + WW + 2;

	logic signed [SW:0]   diff;
	logic signed [PW-1:0] prod;
	logic signed [PW-1:0] scaled;
	logic signed [PW-1:0] mixed;
	sample_t              result;

	// step toward the neighbour
	assign diff = i_data1 - i_data0;

	// weight is unsigned, zero extend before the signed multiply
	assign prod = diff * $signed({1'b0, i_weight});

	// divide by speed, arithmetic shift keeps sign
	assign scaled = prod >>> i_shift;
	assign mixed  = scaled + i_data0;

	// weight is 0 in fast play so the sum already holds there
	// result lies between the two words, truncation is lossless
	assign result = i_interp ? sample_t'(mixed) : i_data0;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_dac_valid <= 1'b0;
		end else begin
			o_dac_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_dac_data <= result;
		end
	end

endmodule

`default_nettype wire

// File: logic/aud_top.sv
`default_nettype none

module aud_top (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_start,
	input  logic                i_pause,
	input  logic                i_stop,
	input  logic                i_play_mode,
	input  logic                i_fast,
	input  logic                i_interp,
	input  aud_pkg::shift_t     i_speed,
	input  logic                i_adc_valid,
	input  aud_pkg::sample_t    i_adc_data,
	input  logic                i_dac_req,
	output logic                o_dac_valid,
	output aud_pkg::sample_t    o_dac_data,
	output aud_pkg::aud_state_e o_state,
	output aud_pkg::len_t       o_len
);

	import aud_pkg::*;

	// control
	aud_state_e state;
	logic       full;
	logic       rg_end;

	// record side
	logic    wr_en;
	addr_t   wr_addr;
	sample_t wr_data;

	// rate generator to memory
	logic   rd_en;
	addr_t  rd_addr0;
	addr_t  rd_addr1;
	wgt_t   rg_weight;
	shift_t rg_shift;

	// memory to output stage
	logic    rd_valid;
	sample_t rd_data0;
	sample_t rd_data1;
	wgt_t    ram_weight;
	shift_t  ram_shift;

	assign o_state = state;

	aud_ctrl i_aud_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_pause     (i_pause),
		.i_stop      (i_stop),
		.i_play_mode (i_play_mode),
		.i_full      (full),
		.i_end       (rg_end),
		.o_state     (state)
	);

	aud_capture i_aud_capture (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_state     (state),
		.i_adc_valid (i_adc_valid),
		.i_adc_data  (i_adc_data),
		.o_wr_en     (wr_en),
		.o_wr_addr   (wr_addr),
		.o_wr_data   (wr_data),
		.o_len       (o_len),
		.o_full      (full)
	);

	aud_sample_ram i_aud_sample_ram (
		.i_clk      (i_clk),
		.i_wr_en    (wr_en),
		.i_wr_addr  (wr_addr),
		.i_wr_data  (wr_data),
		.i_rd_en    (rd_en),
		.i_rd_addr0 (rd_addr0),
		.i_rd_addr1 (rd_addr1),
		.i_weight   (rg_weight),
		.i_shift    (rg_shift),
		.o_rd_valid (rd_valid),
		.o_rd_data0 (rd_data0),
		.o_rd_data1 (rd_data1),
		.o_weight   (ram_weight),
		.o_shift    (ram_shift)
	);

	aud_rate_gen i_aud_rate_gen (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_state    (state),
		.i_dac_req  (i_dac_req),
		.i_fast     (i_fast),
		.i_speed    (i_speed),
		.i_len      (o_len),
		.o_rd_en    (rd_en),
		.o_rd_addr0 (rd_addr0),
		.o_rd_addr1 (rd_addr1),
		.o_weight   (rg_weight),
		.o_shift    (rg_shift),
		.o_end      (rg_end)
	);

	aud_interp i_aud_interp (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_interp    (i_interp),
		.i_valid     (rd_valid),
		.i_data0     (rd_data0),
		.i_data1     (rd_data1),
		.i_weight    (ram_weight),
		.i_shift     (ram_shift),
		.o_dac_valid (o_dac_valid),
		.o_dac_data  (o_dac_data)
	);

endmodule

`default_nettype wire

// File: dv/aud_tb.sv
`default_nettype none

`include "aud_macros.svh"

module aud_tb;

	import aud_pkg::*;

	localparam int N_REC  = 21;
	localparam int GAP    = 2;
	localparam int N_HALF = 8;
	localparam int DRAIN  = 6;
	localparam int MEM    = `AUD_MEM_DEPTH;

	localparam int BTN_START = 0;
	localparam int BTN_PAUSE = 1;
	localparam int BTN_STOP  = 2;

	// rough cycle cost of each test
	localparam int T_REC   = (N_REC + 3) * (GAP + 2) + 30;
	localparam int T_PLAY  = N_REC + DRAIN + 20;
	localparam int T_FAST  = N_REC + 2 * DRAIN + 40;
	localparam int T_SLOW  = 8 * N_REC + 2 * DRAIN + 40;
	localparam int T_PAUSE = (2 * N_HALF + 4) * (GAP + 2) + 2 * N_HALF + 60;
	localparam int T_FULL  = 3 * MEM + 8 + DRAIN + 40;
	localparam int WATCHDOG_CYCLES =
		2 * (T_REC + T_PLAY + T_FAST + T_SLOW + T_PAUSE + T_FULL) + 100;

	logic       i_clk;
	logic       i_rst_n;
	logic       i_start;
	logic       i_pause;
	logic       i_stop;
	logic       i_play_mode;
	logic       i_fast;
	logic       i_interp;
	shift_t     i_speed;
	logic       i_adc_valid;
	sample_t    i_adc_data;
	logic       i_dac_req;
	logic       o_dac_valid;
	sample_t    o_dac_data;
	aud_state_e o_state;
	len_t       o_len;

	// model of the recorded memory and output streams
	sample_t mem_q[$];
	sample_t exp_q[$];
	sample_t got_q[$];
	time     got_t[$];

	int err_cnt;
	int check_cnt;

	aud_top i_aud_top (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_pause     (i_pause),
		.i_stop      (i_stop),
		.i_play_mode (i_play_mode),
		.i_fast      (i_fast),
		.i_interp    (i_interp),
		.i_speed     (i_speed),
		.i_adc_valid (i_adc_valid),
		.i_adc_data  (i_adc_data),
		.i_dac_req   (i_dac_req),
		.o_dac_valid (o_dac_valid),
		.o_dac_data  (o_dac_data),
		.o_state     (o_state),
		.o_len       (o_len)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// output collector, midway between edges
	always @(negedge i_clk) begin
		if (i_rst_n && o_dac_valid) begin
			got_q.push_back(o_dac_data);
			got_t.push_back($time);
		end
	end

	task automatic check_value(input string name, input integer got, input integer exp);
		check_cnt++;
		assert (got === exp) else begin
			err_cnt++;
			$display("FAILED time=%0t %s got=%0d exp=%0d", $time, name, got, exp);
		end
	endtask

	// one-cycle button pulse
	task automatic press(input int which);
		@(posedge i_clk);
		case (which)
			BTN_START: i_start <= 1'b1;
			BTN_PAUSE: i_pause <= 1'b1;
			default:   i_stop  <= 1'b1;
		endcase
		@(posedge i_clk);
		i_start <= 1'b0;
		i_pause <= 1'b0;
		i_stop  <= 1'b0;
	endtask

	// adc strobes with idle gaps, optionally logged in the model
	task automatic send_samples(input int n, input int gap, input bit keep);
		sample_t v;
		for (int i = 0; i < n; i++) begin
			v = sample_t'($urandom);
			@(posedge i_clk);
			i_adc_valid <= 1'b1;
			i_adc_data  <= v;
			@(posedge i_clk);
			i_adc_valid <= 1'b0;
			// memory holds at most MEM words
			if (keep && mem_q.size() < MEM) begin
				mem_q.push_back(v);
			end
			repeat (gap) @(posedge i_clk);
		end
	endtask

	task automatic wait_idle(input int limit);
		int cyc;
		cyc = 0;
		@(negedge i_clk);
		while (o_state != st_idle && cyc < limit) begin
			@(negedge i_clk);
			cyc++;
		end
		check_cnt++;
		assert (o_state == st_idle) else begin
			err_cnt++;
			$display("ERROR: state did not return to idle within %0d cycles", limit);
		end
	endtask

	task automatic start_record();
		mem_q.delete();
		@(posedge i_clk);
		i_play_mode <= 1'b0;
		press(BTN_START);
		@(negedge i_clk);
		check_value("o_state after record start", o_state, st_rec);
	endtask

	// expected playback stream from the stepping and output rules
	function automatic void build_expected(input bit fast, input int s, input bit interp);
		int n;
		int step;
		int p1;
		int x0;
		int x1;
		int v;
		n    = mem_q.size();
		step = 1 << s;
		exp_q.delete();
		if (fast) begin
			for (int p = 0; p < n; p += step) begin
				exp_q.push_back(mem_q[p]);
			end
		end else begin
			for (int p = 0; p < n; p++) begin
				for (int k = 0; k < step; k++) begin
					// neighbour clamps to the last recorded word
					p1 = (p + 1 < n) ? p + 1 : n - 1;
					x0 = mem_q[p];
					x1 = mem_q[p1];
					v  = interp ? x0 + (((x1 - x0) * k) >>> s) : x0;
					exp_q.push_back(sample_t'(v));
				end
			end
		end
	endfunction

	task automatic compare_outputs(input string tag);
		int n;
		check_value({tag, " o_dac_valid count"}, got_q.size(), exp_q.size());
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			check_cnt++;
			assert (got_q[i] == exp_q[i]) else begin
				err_cnt++;
				$display("FAILED time=%0t o_dac_data[%0d] (%s) got=%0d exp=%0d",
					got_t[i], i, tag, got_q[i], exp_q[i]);
			end
		end
	endtask

	// play the whole memory with a request every cycle
	task automatic run_playback(input bit fast, input int s, input bit interp,
			input int pause_after, input string tag);
		int  held;
		time t_req;
		build_expected(fast, s, interp);
		got_q.delete();
		got_t.delete();
		@(posedge i_clk);
		i_play_mode <= 1'b1;
		i_fast      <= fast;
		i_speed     <= shift_t'(s);
		i_interp    <= interp;
		press(BTN_START);
		@(negedge i_clk);
		check_value("o_state after play start", o_state, st_play);
		@(posedge i_clk);
		i_dac_req <= 1'b1;
		t_req = $time;
		if (pause_after > 0) begin
			repeat (pause_after) @(posedge i_clk);
			press(BTN_PAUSE);
			// let in-flight samples drain
			repeat (DRAIN) @(negedge i_clk);
			check_value("o_state in play pause", o_state, st_play_pause);
			held = got_q.size();
			repeat (10) @(negedge i_clk);
			check_value("o_dac_valid count during pause", got_q.size(), held);
			press(BTN_START);
		end
		wait_idle(exp_q.size() + 20);
		@(posedge i_clk);
		i_dac_req <= 1'b0;
		repeat (DRAIN) @(negedge i_clk);
		compare_outputs(tag);
		// three register stages, seen half a cycle into the valid cycle
		if (got_t.size() > 0) begin
			check_value({tag, " first o_dac_valid delay"}, int'(got_t[0] - t_req), 35);
		end
	endtask

	task automatic record_and_stop();
		start_record();
		send_samples(N_REC, GAP, 1'b1);
		press(BTN_STOP);
		wait_idle(10);
		check_value("o_len after record", o_len, N_REC);
		// idle strobes are ignored
		send_samples(3, GAP, 1'b0);
		@(negedge i_clk);
		check_value("o_len after idle strobes", o_len, N_REC);
	endtask

	task automatic normal_speed_play();
		run_playback(1'b0, 0, 1'b0, 0, "normal s=0");
	endtask

	task automatic fast_speed_play();
		for (int s = 1; s <= 2; s++) begin
			run_playback(1'b1, s, 1'b0, 0, $sformatf("fast s=%0d", s));
			// ceil(n / 2^s)
			check_value("fast o_dac_valid count", got_q.size(),
				(N_REC + (1 << s) - 1) >> s);
		end
	endtask

	task automatic slow_speed_play();
		run_playback(1'b0, 2, 1'b0, 0, "slow s=2 hold");
		run_playback(1'b0, 2, 1'b1, 0, "slow s=2 interp");
	endtask

	task automatic pause_and_resume();
		start_record();
		send_samples(N_HALF, GAP, 1'b1);
		press(BTN_PAUSE);
		@(negedge i_clk);
		check_value("o_state in record pause", o_state, st_rec_pause);
		// dropped while paused
		send_samples(4, GAP, 1'b0);
		@(negedge i_clk);
		check_value("o_len in record pause", o_len, N_HALF);
		press(BTN_START);
		send_samples(N_HALF, GAP, 1'b1);
		press(BTN_STOP);
		wait_idle(10);
		check_value("o_len after resume", o_len, 2 * N_HALF);
		// playback proves the resumed address and play position
		run_playback(1'b0, 0, 1'b0, 5, "play with pause");
	endtask

	task automatic memory_full_autostop();
		start_record();
		send_samples(MEM + 4, 0, 1'b1);
		@(negedge i_clk);
		check_value("o_state after full memory", o_state, st_idle);
		check_value("o_len after full memory", o_len, MEM);
		run_playback(1'b0, 0, 1'b0, 0, "full memory");
	endtask

	initial begin
		void'($urandom(32'h0469f84f));
		err_cnt     = 0;
		check_cnt   = 0;
		i_rst_n     = 1'b0;
		i_start     = 1'b0;
		i_pause     = 1'b0;
		i_stop      = 1'b0;
		i_play_mode = 1'b0;
		i_fast      = 1'b0;
		i_interp    = 1'b0;
		i_speed     = '0;
		i_adc_valid = 1'b0;
		i_adc_data  = '0;
		i_dac_req   = 1'b0;
		repeat (5) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		check_value("o_state after reset", o_state, st_idle);
		check_value("o_dac_valid after reset", o_dac_valid, 0);
		check_value("o_len after reset", o_len, 0);

		record_and_stop();
		normal_speed_play();
		fast_speed_play();
		slow_speed_play();
		pause_and_resume();
		memory_full_autostop();

		$display("checks=%0d errors=%0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// bounds the run if the DUT stalls
	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: audio_recorder.f
+incdir+include
logic/aud_pkg.sv
logic/aud_ctrl.sv
logic/aud_capture.sv
logic/aud_sample_ram.sv
logic/aud_rate_gen.sv
logic/aud_interp.sv
logic/aud_top.sv
dv/aud_tb.sv

// File: Bender.yml
package:
  name: audio_recorder

sources:
  - include_dirs:
      - include
    files:
      - logic/aud_pkg.sv
      - logic/aud_ctrl.sv
      - logic/aud_capture.sv
      - logic/aud_sample_ram.sv
      - logic/aud_rate_gen.sv
      - logic/aud_interp.sv
      - logic/aud_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/aud_tb.sv
